// File: frog.mem
// 16 rows of 17 pixels, one palette code per column, 00 is transparent
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 0c 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00

// File: sources.f
+incdir+include
hdl/froggerPkg.sv
hdl/objectHitIf.sv
hdl/pixelDecode.sv
hdl/laneMotion.sv
hdl/objectHit.sv
hdl/colorSelect.sv
hdl/froggerScreen.sv
tests/froggerScreen_tb.sv

// File: Makefile
# Verilator build and run for the frogger screen testbench

TOP ?= froggerScreen_tb
SOURCES ?= sources.f
LOG ?= sim.log
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VERILATOR_FLAGS ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: TOP SOURCES LOG BUILD_DIR VERILATOR VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(SOURCES)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR)
	rm -f $(LOG)

// File: tests/froggerScreen_tb.sv
// Frogger screen testbench
`timescale 1ns/1ps
`include "frogger_params.svh"

module froggerScreen_tb
	import froggerPkg::*;
	();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_ROWS = 4;

	// parking spot for the frog in the top right of the water
	localparam int FROG_AWAY_X = 620;
	localparam int FROG_AWAY_Y = 10;

	// median pixel that no frog or truck in the table ever covers
	localparam int FOLLOW_X = 300;
	localparam int FOLLOW_Y = 245;

	logic clk_1Hz;
	logic reset;
	logic frameStart;
	coordT drawX;
	coordT drawY;
	coordT frogX;
	coordT frogY;
	colorT colorCode;
	logic tableReady;
	integer seed;

	// stimulus table with one entry per row in each queue
	string rowName [$];
	int rowFrames [$];
	int rowFrogX [$];
	int rowFrogY [$];
	int rowDrawX [$];
	int rowDrawY [$];
	int rowExpect [$];

	froggerScreen u_froggerScreen
	(
		.clk_1Hz(clk_1Hz),
		.reset(reset),
		.frameStart(frameStart),
		.drawX(drawX),
		.drawY(drawY),
		.frogX(frogX),
		.frogY(frogY),
		.colorCode(colorCode)
	);

	always #(CLK_PERIOD / 2) clk_1Hz = ~clk_1Hz;

	// ********************************************************************
	// helpers
	// ********************************************************************
	task automatic checkValue(string name, int expected, int actual);
		if (expected != actual)
		begin
			$display("error: test %s expected %0d actual %0d", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "colour mismatch");
		end
	endtask

	task automatic addRow(string name, int frames, int fx, int fy, int dx, int dy, int expected);
		rowName.push_back(name);
		rowFrames.push_back(frames);
		rowFrogX.push_back(fx);
		rowFrogY.push_back(fy);
		rowDrawX.push_back(dx);
		rowDrawY.push_back(dy);
		rowExpect.push_back(expected);
	endtask

	// frame counts are cumulative so each row adds its pulses to the ones before
	task automatic buildTable();
		int randX;
		int randY;
		addRow("waterZone", 0, FROG_AWAY_X, FROG_AWAY_Y, 5, 10, `COLOR_WATER);
		addRow("grassZone", 0, FROG_AWAY_X, FROG_AWAY_Y, 20, 80, `COLOR_GREEN);
		addRow("bayZone", 0, FROG_AWAY_X, FROG_AWAY_Y, 80, 80, `COLOR_WATER);
		addRow("medianZone", 0, FROG_AWAY_X, FROG_AWAY_Y, 300, 245, `COLOR_PURPLE);
		addRow("roadZone", 0, FROG_AWAY_X, FROG_AWAY_Y, 5, 300, `COLOR_GREY);
		addRow("frogInterior", 0, 100, 300, 108, 307, `COLOR_FROG);
		addRow("frogRing", 0, 100, 300, 100, 300, `COLOR_GREY);
		// truck 0 starts at 440 and covers 440..464
		addRow("truckFront", 0, FROG_AWAY_X, FROG_AWAY_Y, 440, 275, `COLOR_RED);
		addRow("truckTail", 0, FROG_AWAY_X, FROG_AWAY_Y, 464, 275, `COLOR_RED);
		addRow("truckAhead", 0, FROG_AWAY_X, FROG_AWAY_Y, 435, 275, `COLOR_GREY);
		addRow("frogOverTruck", 0, 440, 270, 448, 277, `COLOR_FROG);
		// full bar covers x 430..589
		addRow("barFullEnd", 0, FROG_AWAY_X, FROG_AWAY_Y, 589, 460, `COLOR_GREEN);
		addRow("barFullPast", 0, FROG_AWAY_X, FROG_AWAY_Y, 590, 460, `COLOR_GREY);

		// open road rows between the truck lane and the lower median
		for (int i = 0; i < RANDOM_ROWS; i++)
		begin
			randX = $unsigned($random(seed)) % `SCREEN_W;
			randY = 290 + $unsigned($random(seed)) % 120;
			addRow($sformatf("randomRoad%0d", i), 0, FROG_AWAY_X, FROG_AWAY_Y,
				randX, randY, `COLOR_GREY);
		end

		// after five frames truck 0 sits at 435..459
		addRow("truckMovedTail", 5, FROG_AWAY_X, FROG_AWAY_Y, 464, 275, `COLOR_GREY);
		addRow("truckMovedFront", 0, FROG_AWAY_X, FROG_AWAY_Y, 435, 275, `COLOR_RED);
		// after eight frames two bar steps are taken and the width is 158
		addRow("barShrunkEnd", 3, FROG_AWAY_X, FROG_AWAY_Y, 587, 460, `COLOR_GREEN);
		addRow("barShrunkPast", 0, FROG_AWAY_X, FROG_AWAY_Y, 588, 460, `COLOR_GREY);
	endtask

	// run length budget from the table size and its largest frame step
	function automatic int timeoutCycles();
		int maxFrames;
		maxFrames = 0;
		foreach (rowFrames[i])
		begin
			if (rowFrames[i] > maxFrames)
				maxFrames = rowFrames[i];
		end
		return rowName.size() * (maxFrames + 4) + 20;
	endfunction

	task automatic applyRow(int idx);
		// one-cycle frame pulses with a low cycle between them
		for (int n = 0; n < rowFrames[idx]; n++)
		begin
			frameStart = 1'b1;
			@(negedge clk_1Hz);
			frameStart = 1'b0;
			@(negedge clk_1Hz);
		end
		frogX = coordT'(rowFrogX[idx]);
		frogY = coordT'(rowFrogY[idx]);
		drawX = coordT'(rowDrawX[idx]);
		drawY = coordT'(rowDrawY[idx]);
		// decode register takes the pixel
		@(posedge clk_1Hz);
		@(negedge clk_1Hz);
		// a purple pixel follows one cycle behind while the first reaches colorCode
		drawX = coordT'(FOLLOW_X);
		drawY = coordT'(FOLLOW_Y);
		@(posedge clk_1Hz);
		@(negedge clk_1Hz);
		checkValue(rowName[idx], rowExpect[idx], colorCode);
	endtask

	// ********************************************************************
	// main sequence
	// ********************************************************************
	initial
	begin
		seed = 32'hb6b5;
		tableReady = 1'b0;
		clk_1Hz = 1'b0;
		reset = 1'b1;
		frameStart = 1'b0;
		drawX = '0;
		drawY = '0;
		frogX = coordT'(FROG_AWAY_X);
		frogY = coordT'(FROG_AWAY_Y);

		buildTable();
		tableReady = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk_1Hz);
		@(negedge clk_1Hz);
		checkValue("resetGrey", `COLOR_GREY, colorCode);
		reset = 1'b0;

		for (int i = 0; i < rowName.size(); i++)
			applyRow(i);

		$display("TEST PASS");
		$finish;
	end

	// watchdog
	initial
	begin
		wait (tableReady);
		#(timeoutCycles() * CLK_PERIOD);
		$display("error: run timed out after %0d cycles", timeoutCycles());
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: hdl/froggerScreen.sv
// Frogger screen pixel pipeline
`timescale 1ns/1ps

module froggerScreen
	import froggerPkg::*;
(
	input logic clk_1Hz,
	input logic reset,
	input logic frameStart,
	input coordT drawX,
	input coordT drawY,
	input coordT frogX,
	input coordT frogY,
	output colorT colorCode
);

	coordT pixelX;
	coordT pixelY;
	zoneT zone;

	objectHitIf hitBus ();

	// decode, 1 cycle
	pixelDecode u_pixelDecode
	(
		.clk_1Hz(clk_1Hz),
		.reset(reset),
		.drawX(drawX),
		.drawY(drawY),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.zone(zone)
	);

	// execute, combinational on the decode registers
	objectHit u_objectHit
	(
		.clk_1Hz(clk_1Hz),
		.reset(reset),
		.frameStart(frameStart),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.frogX(frogX),
		.frogY(frogY),
		.hits(hitBus.exec)
	);

	// result, 1 cycle
	colorSelect u_colorSelect
	(
		.clk_1Hz(clk_1Hz),
		.reset(reset),
		.zone(zone),
		.hits(hitBus.result),
		.colorCode(colorCode)
	);

endmodule

// File: hdl/colorSelect.sv
// Colour select result stage
`timescale 1ns/1ps
`include "frogger_params.svh"

module colorSelect
	import froggerPkg::*;
(
	input logic clk_1Hz,
	input logic reset,
	input zoneT zone,
	objectHitIf.result hits,
	output colorT colorCode
);

	colorT colorNext;

	// ********************************************************************
	// priority mux, sprites over medians over bar over background
	// ********************************************************************
	always_comb
	begin
		if (hits.frogHit)
			colorNext = hits.frogColor;
		else if (hits.truckHit)
			colorNext = `COLOR_RED;
		else if (zone == zoneMedian)
			colorNext = `COLOR_PURPLE;
		else if (hits.barHit)
			colorNext = `COLOR_GREEN;
		else
		begin
			case (zone)
				zoneBay: colorNext = `COLOR_WATER;
				zoneGrass: colorNext = `COLOR_GREEN;
				zoneWater: colorNext = `COLOR_WATER;
				default: colorNext = `COLOR_GREY;
			endcase
		end
	end

	always_ff @(posedge clk_1Hz)
	begin
		if (reset)
			colorCode <= `COLOR_GREY;
		else
			colorCode <= colorNext;
	end

	// transparent sprite words must never be reported as a hit
	frogOpaque: assert property (@(posedge clk_1Hz) disable iff (reset)
		hits.frogHit |-> hits.frogColor != '0);

endmodule

// File: hdl/objectHit.sv
// Object hit execute stage
`timescale 1ns/1ps
`include "frogger_params.svh"

module objectHit
	import froggerPkg::*;
(
	input logic clk_1Hz,
	input logic reset,
	input logic frameStart,
	input coordT pixelX,
	input coordT pixelY,
	input coordT frogX,
	input coordT frogY,
	objectHitIf.exec hits
);

	localparam int ROM_DEPTH = `FROG_H * `FROG_W;
	localparam int ADDR_W = $clog2(ROM_DEPTH);

	coordT truck0X;
	coordT truck1X;
	coordT truck2X;
	coordT barWidth;
	colorT frogRom [ROM_DEPTH];
	coordT frogOffX;
	coordT frogOffY;
	logic [ADDR_W-1:0] frogAddr;
	logic inFrog;
	colorT frogWord;

	// p lies in [origin, origin + size), no overflow near the top of the range
	function automatic logic inSpan(coordT p, coordT origin, coordT size);
		coordT offset;
		offset = p - origin;
		return (p >= origin) && (offset < size);
	endfunction

	laneMotion u_laneMotion
	(
		.clk_1Hz(clk_1Hz),
		.reset(reset),
		.frameStart(frameStart),
		.truck0X(truck0X),
		.truck1X(truck1X),
		.truck2X(truck2X),
		.barWidth(barWidth)
	);

	// ********************************************************************
	// frog sprite, row-major, code 0 is see-through
	// ********************************************************************
	initial
	begin
		$readmemh("frog.mem", frogRom);
	end

	assign frogOffX = pixelX - frogX;
	assign frogOffY = pixelY - frogY;
	assign inFrog = inSpan(pixelX, frogX, `FROG_W) && inSpan(pixelY, frogY, `FROG_H);
	assign frogAddr = ADDR_W'(frogOffY * `FROG_W + frogOffX);
	assign frogWord = inFrog ? frogRom[frogAddr] : '0;

	assign hits.frogHit = inFrog && (frogWord != '0);
	assign hits.frogColor = frogWord;

	// all three trucks share one lane row
	assign hits.truckHit = inSpan(pixelY, `TRUCK_Y, `TRUCK_H) &&
		(inSpan(pixelX, truck0X, `TRUCK_W) ||
		inSpan(pixelX, truck1X, `TRUCK_W) ||
		inSpan(pixelX, truck2X, `TRUCK_W));

	// empty bar draws nothing
	assign hits.barHit = inSpan(pixelX, `BAR_X, barWidth) && inSpan(pixelY, `BAR_Y, `BAR_H);

endmodule

// File: hdl/laneMotion.sv
// Firetruck lane and timer bar motion
`timescale 1ns/1ps
`include "frogger_params.svh"

module laneMotion
	import froggerPkg::*;
(
	input logic clk_1Hz,
	input logic reset,
	input logic frameStart,
	output coordT truck0X,
	output coordT truck1X,
	output coordT truck2X,
	output coordT barWidth
);

	localparam int TRUCKS = 3;
	localparam coordT TRUCK_START [TRUCKS] = '{`TRUCK0_X, `TRUCK1_X, `TRUCK2_X};
	localparam int COUNT_W = $clog2(`BAR_DIV);

	coordT truckX [TRUCKS];
	logic [COUNT_W-1:0] frameCount;

	// ********************************************************************
	// per-frame update
	// ********************************************************************
	always_ff @(posedge clk_1Hz)
	begin
		if (reset)
		begin
			for (int i = 0; i < TRUCKS; i++)
				truckX[i] <= TRUCK_START[i];
			frameCount <= '0;
			barWidth <= `BAR_FULL;
		end
		else if (frameStart)
		begin
			// trucks drive left and re-enter from the right edge
			for (int i = 0; i < TRUCKS; i++)
			begin
				if (truckX[i] == '0)
					truckX[i] <= `TRUCK_WRAP;
				else
					truckX[i] <= truckX[i] - 1'b1;
			end

			if (frameCount == `BAR_DIV - 1)
			begin
				frameCount <= '0;
				// bar refills once it has run out
				if (barWidth == '0)
					barWidth <= `BAR_FULL;
				else
					barWidth <= barWidth - 1'b1;
			end
			else
				frameCount <= frameCount + 1'b1;
		end
	end

	assign truck0X = truckX[0];
	assign truck1X = truckX[1];
	assign truck2X = truckX[2];

	barWithinFull: assert property (@(posedge clk_1Hz) disable iff (reset)
		barWidth <= `BAR_FULL);

endmodule

// File: hdl/pixelDecode.sv
// Pixel decode stage
`timescale 1ns/1ps
`include "frogger_params.svh"

module pixelDecode
	import froggerPkg::*;
(
	input logic clk_1Hz,
	input logic reset,
	input coordT drawX,
	input coordT drawY,
	output coordT pixelX,
	output coordT pixelY,
	output zoneT zone
);

	zoneT zoneNext;

	// true inside one of the five goal bays
	function automatic logic inBay(coordT x);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < `BAY_COUNT; i++)
		begin
			if (x >= `BAY_X0 + i * `BAY_PITCH && x <= `BAY_X0 + i * `BAY_PITCH + `BAY_SPAN)
				hit = 1'b1;
		end
		return hit;
	endfunction

	// ********************************************************************
	// zone classification, median wins over everything below it
	// ********************************************************************
	always_comb
	begin
		if ((drawY >= `MEDIAN0_TOP && drawY <= `MEDIAN0_TOP + `MEDIAN_SPAN) ||
			(drawY >= `MEDIAN1_TOP && drawY <= `MEDIAN1_TOP + `MEDIAN_SPAN))
			zoneNext = zoneMedian;
		else if (drawY >= `GRASS_TOP && drawY <= `GRASS_END)
		begin
			// bays only open below the top grass strip
			if (drawY >= `BAY_TOP && inBay(drawX))
				zoneNext = zoneBay;
			else
				zoneNext = zoneGrass;
		end
		else if (drawY < `WATER_END)
			zoneNext = zoneWater;
		else
			zoneNext = zoneRoad;
	end

	always_ff @(posedge clk_1Hz)
	begin
		if (reset)
		begin
			pixelX <= '0;
			pixelY <= '0;
			zone <= zoneRoad;
		end
		else
		begin
			pixelX <= drawX;
			pixelY <= drawY;
			zone <= zoneNext;
		end
	end

	// scan source must stay on the visible line
	pixelOnScreen: assert property (@(posedge clk_1Hz) disable iff (reset)
		pixelX < `SCREEN_W);

endmodule

// File: hdl/objectHitIf.sv
// Object hit bundle
`timescale 1ns/1ps

interface objectHitIf
	import froggerPkg::*;
	();

	// frog sprite pixel, opaque only
	logic frogHit;
	colorT frogColor;

	// any firetruck box
	logic truckHit;

	// green timer bar box
	logic barHit;

	modport exec
	(
		output frogHit,
		output frogColor,
		output truckHit,
		output barHit
	);

	modport result
	(
		input frogHit,
		input frogColor,
		input truckHit,
		input barHit
	);

endinterface

// File: hdl/froggerPkg.sv
// Frogger screen types
package froggerPkg;

	// screen coordinate, wide enough for 640 x 480 plus wrap value
	typedef logic [9:0] coordT;

	// 6-bit palette index
	typedef logic [5:0] colorT;

	// background class of one pixel
	typedef enum logic [2:0]
	{
		zoneWater,
		zoneGrass,
		zoneBay,
		zoneMedian,
		zoneRoad
	} zoneT;

endpackage

// File: include/frogger_params.svh
// Frogger screen constants
`ifndef FROGGER_PARAMS_SVH
`define FROGGER_PARAMS_SVH

// ********************************************************************
// screen
// ********************************************************************
`define SCREEN_W 640
`define SCREEN_H 480

// ********************************************************************
// background zones
// ********************************************************************
`define WATER_END 240
`define GRASS_TOP 50
`define GRASS_END 100
`define BAY_TOP 60

// five goal bays, 50-110 then every 120 pixels, inclusive
`define BAY_X0 50
`define BAY_PITCH 120
`define BAY_SPAN 60
`define BAY_COUNT 5

// purple medians, inclusive row spans
`define MEDIAN0_TOP 240
`define MEDIAN1_TOP 420
`define MEDIAN_SPAN 18

// ********************************************************************
// objects
// ********************************************************************
`define FROG_W 17
`define FROG_H 16

`define TRUCK_W 25
`define TRUCK_H 16
`define TRUCK_Y 270
`define TRUCK0_X 440
`define TRUCK1_X 400
`define TRUCK2_X 320
`define TRUCK_WRAP 640

// timer bar, shrinks one pixel every BAR_DIV frames
`define BAR_X 430
`define BAR_Y 455
`define BAR_H 15
`define BAR_FULL 160
`define BAR_DIV 4

// ********************************************************************
// colour codes
// ********************************************************************
`define COLOR_GREEN 2
`define COLOR_RED 3
`define COLOR_PURPLE 9
`define COLOR_WATER 10
`define COLOR_FROG 12
`define COLOR_GREY 13

`endif
